// File: source/mvu_settings.svh
// Sizes and latencies of the matrix-vector unit, included by the RTL and testbench files
`ifndef MVU_SETTINGS_SVH
`define MVU_SETTINGS_SVH

// Lanes, also the vector length
`define MVU_N           4

// Bank address width, 64 words per bank
`define MVU_BANK_AW     6

// Precision field, holds precision minus 1
`define MVU_BPREC       4

`define MVU_BCNTDWN     10      // Job length counter width
`define MVU_BACC        32      // Lane accumulator width

// Pipeline delays behind the address generator
`define MVU_MEM_RD_LAT  1       // Bank read latency
`define MVU_VVP_STAGES  2       // Term stage plus accumulator stage

`endif

// File: source/mvu_cfg_pkg.sv
// Job configuration types shared by the controller, the address generator and the top level
`include "mvu_settings.svh"

package mvu_cfg_pkg;

    typedef logic [`MVU_BANK_AW-1:0] bank_addr_t;   // Address into either bank
    typedef logic [`MVU_BPREC-1:0]   prec_t;        // Bit-planes minus 1
    typedef logic [`MVU_BCNTDWN-1:0] cntdwn_t;      // Job length in run cycles

    // Captured on an accepted start, held for the whole job
    typedef struct packed {
        bank_addr_t ibaseaddr;      // Data bank address of the first plane
        bank_addr_t wbaseaddr;      // Weight bank address of the first plane
        bank_addr_t istride;        // Data plane spacing
        bank_addr_t wstride;        // Weight plane spacing
        prec_t      iprecision;     // Data planes minus 1
        prec_t      wprecision;     // Weight planes minus 1
        logic       d_signed;       // Data MSB plane has negative weight
        logic       w_signed;       // Weight MSB plane has negative weight
        cntdwn_t    countdown;      // Run cycles, normally (ip+1)*(wp+1)
    } job_cfg_t;

endpackage

// File: source/mvu_data_pkg.sv
// Bank word and accumulator types shared by the datapath, the banks and the testbench
`include "mvu_settings.svh"

package mvu_data_pkg;

    // One bit-plane of the input vector, bit k is element k
    typedef logic [`MVU_N-1:0] data_word_t;

    // One bit-plane of the matrix, row j feeds lane j
    typedef logic [`MVU_N-1:0][`MVU_N-1:0] weight_word_t;

    typedef logic signed [`MVU_BACC-1:0] acc_t;     // One lane sum

    // All lane sums, element j is lane j
    typedef acc_t [`MVU_N-1:0] acc_vec_t;

endpackage

// File: source/mvu_step_if.sv
// Per-cycle bit-plane step control from the address generator to the vector product unit
`timescale 1ns/1ps

interface mvu_step_if;

    logic valid;        // A plane pair is addressed this cycle
    logic neg;          // Term of this pair is subtracted
    logic inner_last;   // Last data plane for the current weight plane
    logic first;        // First pair of the job

    modport agu (
        output valid,
        output neg,
        output inner_last,
        output first
    );

    modport vvp (
        input valid,
        input neg,
        input inner_last,
        input first
    );

endinterface

// File: source/mvu_controller.sv
// Job controller, captures the configuration on start and times run, done and irq
`timescale 1ns/1ps
`include "mvu_settings.svh"

module mvu_controller import mvu_cfg_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  job_cfg_t cfg_in,
    output job_cfg_t cfg,
    output logic     run,
    output logic     done,
    output logic     irq
);

    localparam int DLY = `MVU_MEM_RD_LAT + `MVU_VVP_STAGES;    // Drain time after run

    logic         start_q;      // Accepted start, run follows
    cntdwn_t      cnt;          // Remaining run cycles minus 1
    logic [DLY:0] end_sr;       // End of job travelling down the pipeline
    logic         busy;         // Job running or still draining
    logic         last;         // Final run cycle, or an empty job

    assign busy = start_q | run | (|end_sr[DLY-1:0]);
    assign last = (run && cnt == '0) || (start_q && cfg.countdown == '0);
    assign done = end_sr[DLY];                                  // Single-cycle pulse

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_q <= 1'b0;
            cfg     <= '0;
            run     <= 1'b0;
            cnt     <= '0;
            end_sr  <= '0;
            irq     <= 1'b0;
        end else begin
            start_q <= start && !busy;                          // Starts while busy are dropped
            if (start && !busy) begin
                cfg <= cfg_in;
                irq <= 1'b0;                                    // New job acknowledges irq
            end else if (end_sr[DLY-1]) begin
                irq <= 1'b1;                                    // Rises with done
            end
            if (start_q) begin
                run <= (cfg.countdown != '0);
                cnt <= cfg.countdown - 1'b1;
            end else if (run) begin
                if (cnt == '0) run <= 1'b0;
                else           cnt <= cnt - 1'b1;
            end
            end_sr <= {end_sr[DLY-1:0], last};
        end
    end

    // The last term must clear the pipeline before done reports
    a_done_idle: assert property (@(posedge clk) disable iff (!rst_n) done |-> !run);

endmodule

// File: source/mvu_agu.sv
// Bit-plane address generator, walks data planes inside weight planes, both MSB first
`timescale 1ns/1ps

module mvu_agu import mvu_cfg_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  job_cfg_t   cfg,
    output bank_addr_t iaddr,
    output bank_addr_t waddr,
    mvu_step_if.agu    step
);

    prec_t dcnt;        // Data plane index, inner loop
    prec_t wcnt;        // Weight plane index, outer loop
    logic  run_q;       // Run of the previous cycle
    logic  d_msb;       // Data plane is the sign plane
    logic  w_msb;       // Weight plane is the sign plane

    assign d_msb = (dcnt == cfg.iprecision);
    assign w_msb = (wcnt == cfg.wprecision);

    // Plane address is base plus index times stride, wrapping in the bank
    assign iaddr = cfg.ibaseaddr + bank_addr_t'(dcnt) * cfg.istride;
    assign waddr = cfg.wbaseaddr + bank_addr_t'(wcnt) * cfg.wstride;

    assign step.valid      = run;
    assign step.neg        = (cfg.d_signed & d_msb) ^ (cfg.w_signed & w_msb);
    assign step.inner_last = run & (dcnt == '0);
    assign step.first      = run & ~run_q;                  // Rise of run

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dcnt  <= '0;
            wcnt  <= '0;
            run_q <= 1'b0;
        end else begin
            run_q <= run;
            if (!run) begin
                // Preset to the MSB planes so the first run cycle is ready
                dcnt <= cfg.iprecision;
                wcnt <= cfg.wprecision;
            end else if (dcnt == '0) begin
                dcnt <= cfg.iprecision;                     // Restart data planes
                wcnt <= (wcnt == '0) ? cfg.wprecision : wcnt - 1'b1;
            end else begin
                dcnt <= dcnt - 1'b1;
            end
        end
    end

    a_dcnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        run |-> dcnt <= cfg.iprecision);

endmodule

// File: source/mvu_banks.sv
// Data and weight banks with the external controller ports, data access granted while idle
`timescale 1ns/1ps
`include "mvu_settings.svh"

module mvu_banks import mvu_cfg_pkg::*, mvu_data_pkg::*; (
    input  logic         clk,
    input  logic         run,
    input  bank_addr_t   iaddr,
    input  bank_addr_t   waddr,
    output data_word_t   iword,
    output weight_word_t wword,
    input  logic         wrc_en,
    input  bank_addr_t   wrc_addr,
    input  data_word_t   wrc_word,
    output logic         wrc_grnt,
    input  logic         rdc_en,
    input  bank_addr_t   rdc_addr,
    output data_word_t   rdc_word,
    output logic         rdc_grnt,
    input  logic         wrw_en,
    input  bank_addr_t   wrw_addr,
    input  weight_word_t wrw_word
);

    localparam int DEPTH = 2 ** `MVU_BANK_AW;

    data_word_t   dmem [DEPTH];     // Data bit-planes
    weight_word_t wmem [DEPTH];     // Weight bit-planes
    bank_addr_t   rd_addr;          // Shared data read port address
    logic         rd_en;
    data_word_t   dq;               // Data read word, held between reads

    assign wrc_grnt = !run;
    assign rdc_grnt = !run;
    assign rd_addr  = run ? iaddr : rdc_addr;   // AGU owns the port during a job
    assign rd_en    = run | (rdc_en & rdc_grnt);
    assign iword    = dq;
    assign rdc_word = dq;

    always_ff @(posedge clk) begin
        if (wrc_en && wrc_grnt) dmem[wrc_addr] <= wrc_word;
        if (rd_en) dq <= dmem[rd_addr];
    end

    // Weight bank is always writable from outside
    always_ff @(posedge clk) begin
        if (wrw_en) wmem[wrw_addr] <= wrw_word;
        wword <= wmem[waddr];
    end

endmodule

// File: source/mvu_vvp.sv
// Vector product datapath, lane popcount terms into a two-level shift accumulator
`timescale 1ns/1ps
`include "mvu_settings.svh"

module mvu_vvp import mvu_data_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    mvu_step_if.vvp      step,
    input  data_word_t   iword,
    input  weight_word_t wword,
    output acc_vec_t     result
);

    localparam int LAT = `MVU_MEM_RD_LAT;

    logic [3:0] rt_q [LAT];         // Step control delayed to the bank read words
    logic       rt_valid;
    logic       rt_neg;
    logic       rt_inner_last;
    logic       rt_first;
    acc_vec_t   pop;                // Ones per lane of this plane pair
    acc_vec_t   term_q;             // Signed lane terms, stage 1
    logic       s1_valid;
    logic       s1_inner_last;
    logic       s1_first;
    acc_vec_t   inner_q;            // Sum over data planes of one weight plane
    acc_vec_t   inner_nx;
    acc_vec_t   outer_nx;
    acc_vec_t   outer_q;            // Sum over weight planes, the lane results
    logic       ifresh;             // Next term opens a new inner sum
    logic       ofresh;             // Next outer update opens a new job
    logic       ifresh_now;
    logic       ofresh_now;

    assign {rt_valid, rt_neg, rt_inner_last, rt_first} = rt_q[LAT-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LAT; i++) rt_q[i] <= '0;
        end else begin
            rt_q[0] <= {step.valid, step.neg, step.inner_last, step.first};
            for (int i = 1; i < LAT; i++) rt_q[i] <= rt_q[i-1];
        end
    end

    // Stage 1: row AND plane, count the ones
    always_comb begin
        for (int j = 0; j < `MVU_N; j++) pop[j] = acc_t'($countones(wword[j] & iword));
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < `MVU_N; j++) term_q[j] <= rt_neg ? -pop[j] : pop[j];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid      <= 1'b0;
            s1_inner_last <= 1'b0;
            s1_first      <= 1'b0;
        end else begin
            s1_valid      <= rt_valid;
            s1_inner_last <= rt_inner_last;
            s1_first      <= rt_first;
        end
    end

    // Stage 2: MSB first, so double then add
    assign ifresh_now = s1_first | ifresh;
    assign ofresh_now = s1_first | ofresh;

    always_comb begin
        for (int j = 0; j < `MVU_N; j++) begin
            inner_nx[j] = (ifresh_now ? acc_t'(0) : acc_t'(inner_q[j] <<< 1)) + term_q[j];
            outer_nx[j] = (ofresh_now ? acc_t'(0) : acc_t'(outer_q[j] <<< 1)) + inner_nx[j];
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) inner_q <= inner_nx;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ifresh  <= 1'b1;
            ofresh  <= 1'b1;
            outer_q <= '0;
        end else if (s1_valid) begin
            ifresh <= s1_inner_last;
            ofresh <= ofresh_now & !s1_inner_last;
            if (s1_inner_last) outer_q <= outer_nx;    // Weight plane done
        end
    end

    assign result = outer_q;        // Holds after the job until the next one writes

endmodule

// File: source/mvu_top.sv
// Top level of the matrix-vector unit, plain configuration, bank and result ports
`timescale 1ns/1ps

module mvu_top import mvu_cfg_pkg::*, mvu_data_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  bank_addr_t   ibaseaddr,
    input  bank_addr_t   wbaseaddr,
    input  bank_addr_t   istride,
    input  bank_addr_t   wstride,
    input  prec_t        iprecision,
    input  prec_t        wprecision,
    input  logic         d_signed,
    input  logic         w_signed,
    input  cntdwn_t      countdown,
    input  logic         wrc_en,
    input  bank_addr_t   wrc_addr,
    input  data_word_t   wrc_word,
    output logic         wrc_grnt,
    input  logic         rdc_en,
    input  bank_addr_t   rdc_addr,
    output data_word_t   rdc_word,
    output logic         rdc_grnt,
    input  logic         wrw_en,
    input  bank_addr_t   wrw_addr,
    input  weight_word_t wrw_word,
    output logic         done,
    output logic         irq,
    output acc_t         result_0,
    output acc_t         result_1,
    output acc_t         result_2,
    output acc_t         result_3
);

    job_cfg_t     cfg_in;       // Live configuration from the ports
    job_cfg_t     cfg;          // Captured for the running job
    logic         run;
    bank_addr_t   iaddr;
    bank_addr_t   waddr;
    data_word_t   iword;
    weight_word_t wword;
    acc_vec_t     result;

    mvu_step_if step_bus();

    assign cfg_in = '{ibaseaddr: ibaseaddr, wbaseaddr: wbaseaddr, istride: istride,
                      wstride: wstride, iprecision: iprecision, wprecision: wprecision,
                      d_signed: d_signed, w_signed: w_signed, countdown: countdown};

    mvu_controller u_ctrl (.clk, .rst_n, .start, .cfg_in, .cfg, .run, .done, .irq);

    mvu_agu u_agu (.clk, .rst_n, .run, .cfg, .iaddr, .waddr, .step(step_bus.agu));

    mvu_banks u_banks (
        .clk, .run, .iaddr, .waddr, .iword, .wword,
        .wrc_en, .wrc_addr, .wrc_word, .wrc_grnt,
        .rdc_en, .rdc_addr, .rdc_word, .rdc_grnt,
        .wrw_en, .wrw_addr, .wrw_word
    );

    mvu_vvp u_vvp (.clk, .rst_n, .step(step_bus.vvp), .iword, .wword, .result);

    assign result_0 = result[0];
    assign result_1 = result[1];
    assign result_2 = result[2];
    assign result_3 = result[3];

endmodule

// File: bench/tb_mvu_tasks.svh
// Drive tasks, typed checks, reference model and random source, included inside the testbench top
`ifndef TB_MVU_TASKS_SVH
`define TB_MVU_TASKS_SVH

// Every task starts and ends half a nanosecond after a rising edge
task automatic to_drive_point();
    @(posedge clk);
    #0.5;
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function logic [31:0] next_random();
    rng = xorshift32(rng);              // Advances the shared state
    return rng;
endfunction

task automatic check_acc(input string name, input acc_t exp, input acc_t act);
    if (exp !== act) begin
        err_cnt++;
        $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
    if (exp !== act) begin
        err_cnt++;
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        err_cnt++;
        $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic write_data(input bank_addr_t a, input data_word_t w);
    wrc_en      = 1'b1;
    wrc_addr    = a;
    wrc_word    = w;
    shadow_d[a] = w;                    // Only called while idle
    to_drive_point();
    wrc_en = 1'b0;
endtask

task automatic write_weight(input bank_addr_t a, input weight_word_t w);
    wrw_en      = 1'b1;
    wrw_addr    = a;
    wrw_word    = w;
    shadow_w[a] = w;
    to_drive_point();
    wrw_en = 1'b0;
endtask

// Word comes back one cycle after the request
task automatic read_check(input string name, input bank_addr_t a);
    rdc_en   = 1'b1;
    rdc_addr = a;
    to_drive_point();
    rdc_en = 1'b0;
    check_word(name, shadow_d[a], rdc_word);
endtask

// Slices the raw operands into bit-planes at the job's base and stride
task automatic load_operands();
    data_word_t   dw;
    weight_word_t ww;
    for (int p = 0; p <= int'(job.iprecision); p++) begin
        for (int k = 0; k < `MVU_N; k++) dw[k] = op_d[k][p];
        write_data(job.ibaseaddr + bank_addr_t'(p) * job.istride, dw);
    end
    for (int p = 0; p <= int'(job.wprecision); p++) begin
        for (int j = 0; j < `MVU_N; j++) begin
            for (int k = 0; k < `MVU_N; k++) ww[j][k] = op_w[j][k][p];
        end
        write_weight(job.wbaseaddr + bank_addr_t'(p) * job.wstride, ww);
    end
endtask

// Element k rebuilt from the stored planes, MSB plane counts negative when signed
function automatic int data_value(input int k);
    int         v;
    bank_addr_t a;
    v = 0;
    for (int p = 0; p <= int'(job.iprecision); p++) begin
        a = job.ibaseaddr + bank_addr_t'(p) * job.istride;
        if (shadow_d[a][k]) v += (1 << p);
    end
    if (job.d_signed && v >= (1 << int'(job.iprecision))) v -= (2 << int'(job.iprecision));
    return v;
endfunction

function automatic int weight_value(input int j, input int k);
    int         v;
    bank_addr_t a;
    v = 0;
    for (int p = 0; p <= int'(job.wprecision); p++) begin
        a = job.wbaseaddr + bank_addr_t'(p) * job.wstride;
        if (shadow_w[a][j][k]) v += (1 << p);
    end
    if (job.w_signed && v >= (1 << int'(job.wprecision))) v -= (2 << int'(job.wprecision));
    return v;
endfunction

function automatic acc_t model_lane(input int j);
    int sum;
    sum = 0;
    for (int k = 0; k < `MVU_N; k++) sum += weight_value(j, k) * data_value(k);
    return acc_t'(sum);
endfunction

task automatic start_job();
    start = 1'b1;
    to_drive_point();
    start = 1'b0;
endtask

task automatic wait_done(input string name);
    int n;
    n = 0;
    while (!done && n < TIMEOUT) begin
        to_drive_point();
        n++;
    end
    if (!done) begin
        tmo_cnt++;
        $display("%s: no done pulse within %0d cycles", name, TIMEOUT);
    end
endtask

// One full job, irq and all lanes checked against the model
task automatic run_job(input string name);
    start_job();
    check_flag({name, " irq_after_start"}, 1'b0, irq);
    wait_done(name);
    check_flag({name, " irq_after_done"}, 1'b1, irq);
    for (int j = 0; j < `MVU_N; j++) begin
        check_acc($sformatf("%s lane %0d", name, j), model_lane(j), res[j]);
    end
endtask

`endif

// File: bench/tb_mvu_top.sv
// Testbench top of the matrix-vector unit, runs the directed tests against mvu_top and reports
`timescale 1ns/1ps
`include "mvu_settings.svh"

module tb_mvu_top import mvu_cfg_pkg::*, mvu_data_pkg::*; ();

    localparam int TIMEOUT = 200;       // Cycles any single wait may take

    logic         clk;
    logic         rst_n;
    logic         start;
    job_cfg_t     job;                  // Configuration on the DUT ports
    logic         wrc_en;
    bank_addr_t   wrc_addr;
    data_word_t   wrc_word;
    logic         wrc_grnt;
    logic         rdc_en;
    bank_addr_t   rdc_addr;
    data_word_t   rdc_word;
    logic         rdc_grnt;
    logic         wrw_en;
    bank_addr_t   wrw_addr;
    weight_word_t wrw_word;
    logic         done;
    logic         irq;
    acc_vec_t     res;                  // Lane results, element j is result_j

    int           err_cnt = 0;          // Wrong values
    int           tmo_cnt = 0;          // Waits that ran out
    logic [31:0]  rng = 32'h1f8d;       // Xorshift state
    data_word_t   shadow_d [64];        // What the data bank should hold
    weight_word_t shadow_w [64];        // What the weight bank should hold
    logic [15:0]  op_d [`MVU_N];        // Raw data operands, low bits used
    logic [15:0]  op_w [`MVU_N][`MVU_N];    // Raw weights, row j feeds lane j

    always #2 clk = ~clk;               // 4 ns period

    mvu_top uut (
        .clk, .rst_n, .start,
        .ibaseaddr(job.ibaseaddr), .wbaseaddr(job.wbaseaddr),
        .istride(job.istride), .wstride(job.wstride),
        .iprecision(job.iprecision), .wprecision(job.wprecision),
        .d_signed(job.d_signed), .w_signed(job.w_signed), .countdown(job.countdown),
        .wrc_en, .wrc_addr, .wrc_word, .wrc_grnt,
        .rdc_en, .rdc_addr, .rdc_word, .rdc_grnt,
        .wrw_en, .wrw_addr, .wrw_word,
        .done, .irq,
        .result_0(res[0]), .result_1(res[1]), .result_2(res[2]), .result_3(res[3])
    );

    `include "tb_mvu_tasks.svh"

    task automatic test_unsigned();
        job = '{ibaseaddr: 0, wbaseaddr: 0, istride: 1, wstride: 1, iprecision: 1,
                wprecision: 1, d_signed: 0, w_signed: 0, countdown: 4};
        for (int k = 0; k < `MVU_N; k++) begin
            op_d[k] = 16'(3 - k);
            for (int j = 0; j < `MVU_N; j++) op_w[j][k] = 16'(j + k);    // Wraps to 2 bits
        end
        load_operands();
        run_job("unsigned_2x2");
    endtask

    task automatic test_signed();
        job = '{ibaseaddr: 0, wbaseaddr: 0, istride: 1, wstride: 1, iprecision: 2,
                wprecision: 2, d_signed: 1, w_signed: 1, countdown: 9};
        op_d[0] = 16'hfffc;             // -4
        op_d[1] = 16'h0003;
        op_d[2] = 16'hffff;             // -1
        op_d[3] = 16'h0002;
        for (int j = 0; j < `MVU_N; j++) begin
            for (int k = 0; k < `MVU_N; k++) op_w[j][k] = 16'(j - k);   // -3 to 3
        end
        load_operands();
        run_job("signed_3x3");
    endtask

    task automatic test_mixed();
        job = '{ibaseaddr: 10, wbaseaddr: 20, istride: 3, wstride: 5, iprecision: 2,
                wprecision: 1, d_signed: 1, w_signed: 0, countdown: 6};
        op_d[0] = 16'hfffd;             // -3
        op_d[1] = 16'h0002;
        op_d[2] = 16'hffff;
        op_d[3] = 16'h0003;
        for (int j = 0; j < `MVU_N; j++) begin
            for (int k = 0; k < `MVU_N; k++) op_w[j][k] = 16'(2 * j + k);
        end
        load_operands();
        run_job("mixed_stride");
    endtask

    task automatic test_ctrl_access();
        int n;
        for (int i = 0; i < 4; i++) write_data(bank_addr_t'(48 + i), data_word_t'(5 * i + 3));
        for (int i = 0; i < 4; i++) read_check("ctrl_readback", bank_addr_t'(48 + i));
        start_job();                    // Reuses the mixed job already in the banks
        n = 0;
        while (rdc_grnt && n < TIMEOUT) begin
            to_drive_point();
            n++;
        end
        if (rdc_grnt) begin
            tmo_cnt++;
            $display("ctrl_access: read grant never dropped during the job");
        end
        check_flag("ctrl_wrc_grnt_run", 1'b0, wrc_grnt);
        wrc_en   = 1'b1;                // Write attempt while the AGU owns the bank
        wrc_addr = 6'd48;
        wrc_word = ~shadow_d[48];
        to_drive_point();
        wrc_en = 1'b0;
        wait_done("ctrl_access");
        check_flag("ctrl_rdc_grnt_idle", 1'b1, rdc_grnt);
        read_check("ctrl_blocked_write", 6'd48);     // Shadow kept the old word
    endtask

    task automatic test_irq_random();
        logic [31:0] r;
        check_flag("irq_held", 1'b1, irq);          // Still set by the last job
        for (int n = 0; n < 10; n++) begin
            r = next_random();
            job.iprecision = prec_t'(r[1:0]);       // 1 to 4 planes each
            job.wprecision = prec_t'(r[3:2]);
            job.d_signed   = r[4];
            job.w_signed   = r[5];
            job.ibaseaddr  = bank_addr_t'(r[11:6]);
            job.wbaseaddr  = bank_addr_t'(r[17:12]);
            job.istride    = bank_addr_t'(r[20:18]) + 6'd1;
            job.wstride    = bank_addr_t'(r[23:21]) + 6'd1;
            job.countdown  = cntdwn_t'((int'(job.iprecision) + 1) * (int'(job.wprecision) + 1));
            for (int k = 0; k < `MVU_N; k++) begin
                r = next_random();
                op_d[k] = r[15:0];
                for (int j = 0; j < `MVU_N; j++) begin
                    r = next_random();
                    op_w[j][k] = r[15:0];
                end
            end
            load_operands();
            run_job($sformatf("random_%0d", n));
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        job      = '0;
        wrc_en   = 1'b0;
        wrc_addr = '0;
        wrc_word = '0;
        rdc_en   = 1'b0;
        rdc_addr = '0;
        wrw_en   = 1'b0;
        wrw_addr = '0;
        wrw_word = '0;
        repeat (10) @(posedge clk);
        #0.5 rst_n = 1'b1;
        check_flag("reset_irq", 1'b0, irq);
        check_flag("reset_grant", 1'b1, wrc_grnt);
        check_flag("reset_rd_grant", 1'b1, rdc_grnt);
        for (int j = 0; j < `MVU_N; j++) check_acc("reset_result", '0, res[j]);
        test_unsigned();
        test_signed();
        test_mixed();
        test_ctrl_access();
        test_irq_random();
        $display("Errors: %0d wrong values, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
+incdir+bench
source/mvu_cfg_pkg.sv
source/mvu_data_pkg.sv
source/mvu_step_if.sv
source/mvu_controller.sv
source/mvu_agu.sv
source/mvu_banks.sv
source/mvu_vvp.sv
source/mvu_top.sv
bench/tb_mvu_top.sv

// File: run.sh
#!/bin/sh
# Builds the MVU testbench with Verilator, runs it and checks the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_mvu_top -f flist.f
out=$(./obj_dir/Vtb_mvu_top)
echo "$out"
if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1
